// File: Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = led_tb
FILELIST  = files.f
OBJDIR    = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf $(OBJDIR)

// File: files.f
logic/bus_pkg.sv
logic/pwm_pkg.sv
logic/bus_decode.sv
logic/pwm_led.sv
logic/led_out_stage.sv
logic/led_subsys_top.sv
sim/led_props.sv
sim/led_checker.sv
sim/led_tb.sv

// File: logic/bus_decode.sv
`timescale 1ns/10ps
`default_nettype none

module bus_decode
	import bus_pkg::*;
	import pwm_pkg::*;
(
	input  logic                 CLK,
	input  logic                 RSTb,
	input  logic [ADDR_BITS-1:0] address,
	input  logic                 wr,
	input  logic [PWM_BITS-1:0]  duty_r,
	input  logic [PWM_BITS-1:0]  duty_g,
	input  logic [PWM_BITS-1:0]  duty_b,
	input  logic [1:0]           ctrl,
	output logic                 wr_red,
	output logic                 wr_green,
	output logic                 wr_blue,
	output logic                 wr_ctrl,
	output logic [DATA_BITS-1:0] data_out
);

	logic [DATA_BITS-1:0] rd_data;
	logic [DATA_BITS-1:0] data_q;

	// write selects follow WR and the address directly.
	always_comb begin
		wr_red   = 1'b0;
		wr_green = 1'b0;
		wr_blue  = 1'b0;
		wr_ctrl  = 1'b0;
		if (wr) begin
			case (address)
				ADDR_RED:   wr_red   = 1'b1;
				ADDR_GREEN: wr_green = 1'b1;
				ADDR_BLUE:  wr_blue  = 1'b1;
				ADDR_CTRL:  wr_ctrl  = 1'b1;
				default:    ;	// unmapped.
			endcase
		end
	end

	// read mux, zero extended to the bus width.
	always_comb begin
		rd_data = '0;
		case (address)
			ADDR_RED:   rd_data[PWM_BITS-1:0] = duty_r;
			ADDR_GREEN: rd_data[PWM_BITS-1:0] = duty_g;
			ADDR_BLUE:  rd_data[PWM_BITS-1:0] = duty_b;
			ADDR_CTRL:  rd_data[1:0]          = ctrl;
			default:    rd_data = '0;
		endcase
	end

	// read data lags the address by one cycle.
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			data_q <= '0;
		end else begin
			data_q <= rd_data;
		end
	end

	assign data_out = data_q;

endmodule

`default_nettype wire

// File: logic/bus_pkg.sv
`default_nettype none

package bus_pkg;

	// data bus of the soft CPU.
	localparam int ADDR_BITS = 8;
	localparam int DATA_BITS = 16;

	// register map of the LED peripheral.
	localparam logic [ADDR_BITS-1:0] ADDR_RED   = 'h00;	// red duty.
	localparam logic [ADDR_BITS-1:0] ADDR_GREEN = 'h01;	// green duty.
	localparam logic [ADDR_BITS-1:0] ADDR_BLUE  = 'h02;	// blue duty.
	localparam logic [ADDR_BITS-1:0] ADDR_CTRL  = 'h03;	// enable and invert.

	// any other address reads zero and drops writes.

endpackage

`default_nettype wire

// File: logic/led_out_stage.sv
`timescale 1ns/10ps
`default_nettype none

module led_out_stage
	import bus_pkg::*;
	import pwm_pkg::*;
(
	input  logic       CLK,
	input  logic       RSTb,
	input  logic [1:0] data_in,
	input  logic       wr_ctrl,
	input  logic       pwm_r,
	input  logic       pwm_g,
	input  logic       pwm_b,
	output logic [1:0] ctrl,
	output logic       r,
	output logic       g,
	output logic       b
);

	logic [1:0]              ctrl_q;
	logic [PWM_CHANNELS-1:0] pwm_in;
	logic [PWM_CHANNELS-1:0] pin_d;
	logic [PWM_CHANNELS-1:0] pin_q;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			ctrl_q <= '0;
		end else if (wr_ctrl) begin
			ctrl_q <= data_in;
		end
	end

	assign pwm_in = {pwm_b, pwm_g, pwm_r};

	// disabled pins rest at the invert level.
	always_comb begin
		for (int i = 0; i < PWM_CHANNELS; i++) begin
			if (ctrl_q[CTRL_EN]) begin
				pin_d[i] = pwm_in[i] ^ ctrl_q[CTRL_INV];
			end else begin
				pin_d[i] = ctrl_q[CTRL_INV];
			end
		end
	end

	// plain registered pins in place of the current sink driver.
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pin_q <= '0;
		end else begin
			pin_q <= pin_d;
		end
	end

	assign ctrl = ctrl_q;
	assign r = pin_q[0];
	assign g = pin_q[1];
	assign b = pin_q[2];

endmodule

`default_nettype wire

// File: logic/led_subsys_top.sv
`timescale 1ns/10ps
`default_nettype none

module led_subsys_top
	import bus_pkg::*;
(
	input  logic                 CLK,
	input  logic                 RSTb,
	input  logic [ADDR_BITS-1:0] ADDRESS,
	input  logic [DATA_BITS-1:0] DATA_IN,
	input  logic                 WR,
	output logic [DATA_BITS-1:0] DATA_OUT,
	output logic                 r,
	output logic                 g,
	output logic                 b
);

	// write selects from the decoder.
	logic wr_red;
	logic wr_green;
	logic wr_blue;
	logic wr_ctrl;

	// read back paths.
	logic [7:0] duty_r;
	logic [7:0] duty_g;
	logic [7:0] duty_b;
	logic [1:0] ctrl;

	// waveforms into the output stage.
	logic pwm_r;
	logic pwm_g;
	logic pwm_b;

	bus_decode u_decode (
		.CLK      (CLK),
		.RSTb     (RSTb),
		.address  (ADDRESS),
		.wr       (WR),
		.duty_r   (duty_r),
		.duty_g   (duty_g),
		.duty_b   (duty_b),
		.ctrl     (ctrl),
		.wr_red   (wr_red),
		.wr_green (wr_green),
		.wr_blue  (wr_blue),
		.wr_ctrl  (wr_ctrl),
		.data_out (DATA_OUT)
	);

	pwm_led u_pwm (
		.CLK      (CLK),
		.RSTb     (RSTb),
		.data_in  (DATA_IN[7:0]),	// duty keeps the low byte.
		.wr_red   (wr_red),
		.wr_green (wr_green),
		.wr_blue  (wr_blue),
		.duty_r   (duty_r),
		.duty_g   (duty_g),
		.duty_b   (duty_b),
		.pwm_r    (pwm_r),
		.pwm_g    (pwm_g),
		.pwm_b    (pwm_b)
	);

	led_out_stage u_out (
		.CLK     (CLK),
		.RSTb    (RSTb),
		.data_in (DATA_IN[1:0]),	// enable and invert.
		.wr_ctrl (wr_ctrl),
		.pwm_r   (pwm_r),
		.pwm_g   (pwm_g),
		.pwm_b   (pwm_b),
		.ctrl    (ctrl),
		.r       (r),
		.g       (g),
		.b       (b)
	);

endmodule

`default_nettype wire

// File: logic/pwm_led.sv
`timescale 1ns/10ps
`default_nettype none

module pwm_led
	import bus_pkg::*;
	import pwm_pkg::*;
(
	input  logic                CLK,
	input  logic                RSTb,
	input  logic [PWM_BITS-1:0] data_in,
	input  logic                wr_red,
	input  logic                wr_green,
	input  logic                wr_blue,
	output logic [PWM_BITS-1:0] duty_r,
	output logic [PWM_BITS-1:0] duty_g,
	output logic [PWM_BITS-1:0] duty_b,
	output logic                pwm_r,
	output logic                pwm_g,
	output logic                pwm_b
);

	// channel order is red, green, blue.
	logic [PWM_BITS-1:0]     duty [PWM_CHANNELS];
	logic [PWM_CHANNELS-1:0] wr_sel;
	logic [PWM_CHANNELS-1:0] pwm_q;
	logic [PWM_BITS-1:0]     ctr;

	assign wr_sel = {wr_blue, wr_green, wr_red};

	// shared counter with a period of 2**PWM_BITS cycles.
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			ctr <= '0;
		end else begin
			ctr <= ctr + 1'b1;
		end
	end

	// duty registers.
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			for (int i = 0; i < PWM_CHANNELS; i++) begin
				duty[i] <= '0;
			end
		end else begin
			for (int i = 0; i < PWM_CHANNELS; i++) begin
				if (wr_sel[i]) begin
					duty[i] <= data_in;
				end
			end
		end
	end

	// high while the counter is below the duty, so duty 0 never goes high.
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pwm_q <= '0;
		end else begin
			for (int i = 0; i < PWM_CHANNELS; i++) begin
				pwm_q[i] <= (ctr < duty[i]);
			end
		end
	end

	assign duty_r = duty[0];
	assign duty_g = duty[1];
	assign duty_b = duty[2];

	assign pwm_r = pwm_q[0];
	assign pwm_g = pwm_q[1];
	assign pwm_b = pwm_q[2];

endmodule

`default_nettype wire

// File: logic/pwm_pkg.sv
`default_nettype none

package pwm_pkg;

	// counter and duty width, one period is 2**PWM_BITS cycles.
	localparam int PWM_BITS = 8;

	// red, green and blue.
	localparam int PWM_CHANNELS = 3;

	// control register bits.
	localparam int CTRL_EN  = 0;	// pins follow the waveforms.
	localparam int CTRL_INV = 1;	// pins are inverted, also when disabled.

endpackage

`default_nettype wire

// File: sim/led_checker.sv
`timescale 1ns/10ps
`default_nettype none

module led_checker
	import bus_pkg::*;
	import pwm_pkg::*;
(
	input  logic                 CLK,
	input  logic                 RSTb,
	input  logic [ADDR_BITS-1:0] ADDRESS,
	input  logic [DATA_BITS-1:0] DATA_IN,
	input  logic                 WR,
	input  logic [DATA_BITS-1:0] DATA_OUT,
	input  logic                 r,
	input  logic                 g,
	input  logic                 b,
	input  logic                 rd_chk,
	input  logic [DATA_BITS-1:0] rd_exp,
	input  logic                 meas_req,
	output logic                 meas_done,
	output int                   shadow_errs,
	output int                   table_errs,
	output int                   pin_errs
);

	localparam int SETTLE = 3;	// duty, compare and pin registers.
	localparam int PERIOD = 2**PWM_BITS;

	logic [PWM_BITS-1:0]  shadow [4];	// red, green, blue, control.
	logic [DATA_BITS-1:0] exp_q;
	logic [2:0]           pins;
	logic                 busy;
	int                   n_cyc;
	int                   hi [3];
	string                pin_name [3] = '{"r", "g", "b"};

	assign pins = {b, g, r};

	function automatic logic [DATA_BITS-1:0] reg_read(input logic [ADDR_BITS-1:0] a);
		if (a > ADDR_CTRL) begin
			return '0;
		end
		return {{(DATA_BITS-PWM_BITS){1'b0}}, shadow[a[1:0]]};
	endfunction

	// high cycles per period for one channel.
	function automatic int high_exp(input int duty);
		if (!shadow[3][CTRL_EN]) begin
			return shadow[3][CTRL_INV] ? PERIOD : 0;
		end
		return shadow[3][CTRL_INV] ? PERIOD - duty : duty;
	endfunction

	always @(posedge CLK) begin
		if (!RSTb) begin
			shadow = '{default: '0};
			exp_q = '0;
			busy = 1'b0;
			meas_done = 1'b0;
			shadow_errs = 0;
			table_errs = 0;
			pin_errs = 0;
		end else begin
			if (DATA_OUT !== exp_q) begin
				shadow_errs++;
				$display("FAIL %0t DATA_OUT expected %h actual %h", $time, exp_q, DATA_OUT);
			end
			if (rd_chk && DATA_OUT !== rd_exp) begin
				table_errs++;
				$display("FAIL %0t DATA_OUT expected %h actual %h", $time, rd_exp, DATA_OUT);
			end
			exp_q = reg_read(ADDRESS);	// read data lags by one cycle.
			if (WR && ADDRESS == ADDR_CTRL) begin
				shadow[3] = {6'b0, DATA_IN[1:0]};
			end else if (WR && ADDRESS < ADDR_CTRL) begin
				shadow[ADDRESS[1:0]] = DATA_IN[7:0];
			end
			if (!meas_req) begin
				meas_done = 1'b0;
			end
			if (busy) begin
				n_cyc++;
				for (int i = 0; i < 3; i++) begin
					hi[i] += (n_cyc >= SETTLE && pins[i]) ? 1 : 0;
				end
				if (n_cyc == SETTLE + PERIOD - 1) begin
					busy = 1'b0;
					meas_done = 1'b1;
					for (int i = 0; i < 3; i++) begin
						if (hi[i] != high_exp(int'(shadow[i]))) begin
							pin_errs++;
							$display("FAIL %0t %s high cycles expected %0d actual %0d",
								$time, pin_name[i], high_exp(int'(shadow[i])), hi[i]);
						end
					end
				end
			end else if (meas_req && !meas_done) begin
				busy = 1'b1;
				n_cyc = 0;
				hi = '{default: 0};
			end
		end
	end

endmodule

`default_nettype wire

// File: sim/led_props.sv
`timescale 1ns/10ps
`default_nettype none

module led_props
	import pwm_pkg::*;
(
	input logic                CLK,
	input logic                RSTb,
	input logic [PWM_BITS-1:0] ctr,
	input logic [PWM_BITS-1:0] duty_r, duty_g, duty_b,
	input logic                wr_red, wr_green, wr_blue,
	input logic                pwm_r, pwm_g, pwm_b
);

	a_ctr_step: assert property (@(posedge CLK) disable iff (!RSTb)
		$past(RSTb) |-> ctr == $past(ctr) + 1'b1) else $error("counter did not step by one");

	// the waveform lags its duty by one register.
	a_zero_r: assert property (@(posedge CLK) disable iff (!RSTb)
		$past(duty_r) == '0 |-> !pwm_r) else $error("red high with zero duty");
	a_zero_g: assert property (@(posedge CLK) disable iff (!RSTb)
		$past(duty_g) == '0 |-> !pwm_g) else $error("green high with zero duty");
	a_zero_b: assert property (@(posedge CLK) disable iff (!RSTb)
		$past(duty_b) == '0 |-> !pwm_b) else $error("blue high with zero duty");

	a_hold_r: assert property (@(posedge CLK) disable iff (!RSTb)
		!$past(wr_red) |-> $stable(duty_r)) else $error("red duty changed without a write");
	a_hold_g: assert property (@(posedge CLK) disable iff (!RSTb)
		!$past(wr_green) |-> $stable(duty_g)) else $error("green duty changed without a write");
	a_hold_b: assert property (@(posedge CLK) disable iff (!RSTb)
		!$past(wr_blue) |-> $stable(duty_b)) else $error("blue duty changed without a write");

endmodule

bind pwm_led led_props u_props (.CLK, .RSTb, .ctr, .duty_r, .duty_g, .duty_b,
	.wr_red, .wr_green, .wr_blue, .pwm_r, .pwm_g, .pwm_b);

`default_nettype wire

// File: sim/led_tb.sv
`timescale 1ns/10ps
`default_nettype none

module led_tb
	import bus_pkg::*;
();

	localparam logic [1:0] OP_WR = 2'd0;	// write data to addr.
	localparam logic [1:0] OP_RD = 2'd1;	// data is the expected read value.
	localparam logic [1:0] OP_MS = 2'd2;	// count pin high cycles.
	localparam logic [15:0] SEED = 16'd11;
	localparam int TIMEOUT = 600;

	typedef struct packed {
		logic [1:0]           op;
		logic [ADDR_BITS-1:0] addr;
		logic [DATA_BITS-1:0] data;
	} row_t;

	localparam row_t TABLE [23] = '{
		'{OP_RD, 8'h00, 16'h0000}, '{OP_RD, 8'h01, 16'h0000},	// reset values.
		'{OP_RD, 8'h02, 16'h0000}, '{OP_RD, 8'h03, 16'h0000},
		'{OP_MS, 8'h00, 16'h0000},
		'{OP_WR, 8'h00, 16'h12A5},
		'{OP_WR, 8'h01, 16'h3C00},	// duty 0.
		'{OP_WR, 8'h02, 16'hFFFF},	// duty 255.
		'{OP_WR, 8'h03, 16'hFFFD},	// enable only.
		'{OP_WR, 8'h07, 16'hBEEF},	// unmapped.
		'{OP_RD, 8'h00, 16'h00A5}, '{OP_RD, 8'h01, 16'h0000},
		'{OP_RD, 8'h02, 16'h00FF}, '{OP_RD, 8'h03, 16'h0001},
		'{OP_RD, 8'h07, 16'h0000},
		'{OP_MS, 8'h00, 16'h0000},
		'{OP_WR, 8'h03, 16'h0003},	// inverted.
		'{OP_MS, 8'h00, 16'h0000},
		'{OP_WR, 8'h03, 16'h0002},	// disabled with pins resting high.
		'{OP_MS, 8'h00, 16'h0000},
		'{OP_WR, 8'h03, 16'h0000},	// disabled with pins resting low.
		'{OP_MS, 8'h00, 16'h0000},
		'{OP_WR, 8'h03, 16'h0001}
	};

	logic                 CLK;
	logic                 RSTb;
	logic                 WR;
	logic                 r;
	logic                 g;
	logic                 b;
	logic [ADDR_BITS-1:0] ADDRESS;
	logic [DATA_BITS-1:0] DATA_IN;
	logic [DATA_BITS-1:0] DATA_OUT;
	logic [DATA_BITS-1:0] rd_exp;
	logic                 rd_chk;
	logic                 meas_req;
	logic                 meas_done;
	logic [15:0]          lfsr;
	logic [7:0]           rnd;
	int                   shadow_errs;
	int                   table_errs;
	int                   pin_errs;
	int                   timeouts;

	led_subsys_top DUT (.*);
	led_checker u_checker (.*);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic take_byte(output logic [7:0] v);
		for (int i = 0; i < 8; i++) begin
			v[i] = lfsr[0];
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// called on a falling edge, returns on one.
	task automatic apply_row(
		input logic [1:0]           op,
		input logic [ADDR_BITS-1:0] addr,
		input logic [DATA_BITS-1:0] data
	);
		int n;
		ADDRESS = addr;
		DATA_IN = data;
		if (op == OP_WR) begin
			WR = 1'b1;
			@(negedge CLK);
			WR = 1'b0;
		end else if (op == OP_RD) begin
			@(negedge CLK);
			rd_exp = data;
			rd_chk = 1'b1;
			@(negedge CLK);
			rd_chk = 1'b0;
		end else begin
			meas_req = 1'b1;
			n = 0;
			while (!meas_done && n < TIMEOUT) begin
				@(negedge CLK);
				n++;
			end
			if (!meas_done) begin
				timeouts++;
				$display("timeout at %0t: the checker never finished a measurement", $time);
			end
			meas_req = 1'b0;
			@(negedge CLK);
		end
	endtask

	initial begin
		RSTb = 1'b0;
		WR = 1'b0;
		ADDRESS = '0;
		DATA_IN = '0;
		rd_exp = '0;
		rd_chk = 1'b0;
		meas_req = 1'b0;
		timeouts = 0;
		lfsr = SEED;
		repeat (8) @(negedge CLK);
		RSTb = 1'b1;
		foreach (TABLE[i]) begin
			apply_row(TABLE[i].op, TABLE[i].addr, TABLE[i].data);
		end
		for (int k = 0; k < 3; k++) begin	// random duties with enable set.
			for (int c = 0; c < 3; c++) begin
				take_byte(rnd);
				apply_row(OP_WR, 8'(c), {8'h00, rnd});
			end
			apply_row(OP_MS, 8'h00, 16'h0000);
		end
		$display("errors: shadow %0d, table %0d, pin %0d, timeout %0d",
			shadow_errs, table_errs, pin_errs, timeouts);
		if (shadow_errs + table_errs + pin_errs + timeouts == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire
